// ==== build.f ====
design/img_pkg.sv
design/frame_ram.sv
design/pixel_capture.sv
design/fletcher_checksum.sv
design/readout_ctrl.sv
design/img_ctrl_top.sv
tb/img_ctrl_asserts.sv
tb/img_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the image controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module img_ctrl_tb \
    -f build.f --Mdir obj_dir -o img_ctrl_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/img_ctrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== tb/img_ctrl_tb.sv ====
`timescale 1ns/1ps

module img_ctrl_tb;
    import img_pkg::*;

    localparam int CAPTURE_TIMEOUT = 200;
    localparam int READOUT_TIMEOUT = 5000;

    logic                clk;
    logic                arst_n;
    logic                cmd_capture;
    logic                cmd_skip_count;
    logic                cmd_readout;
    logic [HEADER_W-1:0] cmd_header;
    logic                cmd_thumb;
    logic [11:0]         img_d;
    logic                img_fv;
    logic                img_lv;
    logic                readout_trigger;
    word_t               readout_data;
    logic                readout_ready;
    logic                readout_done;
    logic                capture_done;
    logic [COUNT_W-1:0]  capture_pixel_count;
    logic [STAT_W-1:0]   capture_highlight_count;
    logic [STAT_W-1:0]   capture_shadow_count;

    // Reference model of the stored frame and its statistics
    pixel_word_u         model_mem [IMG_PIXELS];
    int                  exp_pixels;
    int                  exp_high;
    int                  exp_shadow;
    word_t               expected_q [$];
    word_t               received_q [$];
    logic [31:0]         lcg_state;
    int                  capture_pulses;
    logic [HEADER_W-1:0] hdr;
    logic [HEADER_W-1:0] hdr_full;

    img_ctrl_top u_dut (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .cmd_capture             (cmd_capture),
        .cmd_skip_count          (cmd_skip_count),
        .cmd_readout             (cmd_readout),
        .cmd_header              (cmd_header),
        .cmd_thumb               (cmd_thumb),
        .img_d                   (img_d),
        .img_fv                  (img_fv),
        .img_lv                  (img_lv),
        .readout_trigger         (readout_trigger),
        .readout_data            (readout_data),
        .readout_ready           (readout_ready),
        .readout_done            (readout_done),
        .capture_done            (capture_done),
        .capture_pixel_count     (capture_pixel_count),
        .capture_highlight_count (capture_highlight_count),
        .capture_shadow_count    (capture_shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Done is a single-cycle pulse, so it is counted as it goes by
    always @(negedge clk) begin
        if (capture_done) begin
            capture_pulses <= capture_pulses + 1;
        end
    end

    // ====================
    // Random numbers
    // ====================
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic int blank_cycles();
        return 1 + int'(next_rand() % 16'd5);
    endfunction

    // A third near white, a third near black, the rest anywhere
    function automatic logic [11:0] pick_pixel();
        logic [15:0] r;
        logic [15:0] mode;
        r    = next_rand();
        mode = next_rand() % 16'd3;
        if (mode == 16'd0) begin
            return {7'h7f, r[4:0]};
        end else if (mode == 16'd1) begin
            return {7'h00, r[4:0]};
        end
        return r[11:0];
    endfunction

    function automatic logic [HEADER_W-1:0] random_header();
        logic [HEADER_W-1:0] h;
        for (int i = 0; i < HEADER_WORDS; i++) begin
            h[i*16 +: 16] = next_rand();
        end
        return h;
    endfunction

    // ====================
    // Checks
    // ====================
    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_stat(input logic [STAT_W-1:0] got, input logic [STAT_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // ====================
    // Capture side
    // ====================
    task automatic start_capture(input logic skip);
        @(negedge clk);
        cmd_capture    = 1'b1;
        cmd_skip_count = skip;
        exp_pixels     = 0;
        exp_high       = 0;
        exp_shadow     = 0;
        @(negedge clk);
        cmd_capture = 1'b0;
        repeat (2) begin
            @(negedge clk);
        end
    endtask

    // One frame of lines with random blanking; store mirrors it into the model
    task automatic drive_frame(input bit store);
        logic [11:0] v;
        pixel_word_u pw;
        int          n;
        @(negedge clk);
        img_fv = 1'b1;
        for (int y = 0; y < IMG_HEIGHT; y++) begin
            n = blank_cycles();
            repeat (n) begin
                @(negedge clk);
            end
            for (int x = 0; x < IMG_WIDTH; x++) begin
                v = pick_pixel();
                @(negedge clk);
                img_lv = 1'b1;
                img_d  = v;
                if (store) begin
                    pw.px.lo_byte   = v[7:0];
                    pw.px.zero      = 4'h0;
                    pw.px.hi_nibble = v[11:8];
                    model_mem[y*IMG_WIDTH + x] = pw;
                    exp_pixels++;
                    // Statistics sample on a 4x4 grid
                    if ((x % 4 == 0) && (y % 4 == 0)) begin
                        if (v[11:5] == 7'h7f) begin
                            exp_high++;
                        end else if (v[11:5] == 7'h00) begin
                            exp_shadow++;
                        end
                    end
                end
            end
            @(negedge clk);
            img_lv = 1'b0;
            img_d  = 12'h000;
        end
        n = blank_cycles();
        repeat (n) begin
            @(negedge clk);
        end
        img_fv = 1'b0;
        n = blank_cycles();
        repeat (n) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_capture(input int target);
        int cycles;
        cycles = 0;
        while (capture_pulses < target) begin
            if (cycles >= CAPTURE_TIMEOUT) begin
                $display("Timeout at %0t: capture_done never pulsed", $time);
                stop_on_error();
            end
            @(negedge clk);
            cycles++;
        end
        check_count(capture_pixel_count, COUNT_W'(exp_pixels), "pixel count");
        check_stat(capture_highlight_count, STAT_W'(exp_high), "highlight count");
        check_stat(capture_shadow_count, STAT_W'(exp_shadow), "shadow count");
    endtask

    // ====================
    // Readout side
    // ====================
    task automatic build_expected(input logic [HEADER_W-1:0] h, input bit thumb);
        int    a;
        int    b;
        word_t sw;
        expected_q.delete();
        for (int i = 0; i < HEADER_WORDS; i++) begin
            expected_q.push_back(h[HEADER_W-1-16*i -: 16]);
        end
        for (int y = 0; y < IMG_HEIGHT; y++) begin
            for (int x = 0; x < IMG_WIDTH; x++) begin
                if (!thumb || ((x % 8 < 2) && (y % 8 < 2))) begin
                    expected_q.push_back(model_mem[y*IMG_WIDTH + x].raw);
                end
            end
        end
        // Fletcher-32 over byte-swapped header and pixel words
        a = 0;
        b = 0;
        foreach (expected_q[i]) begin
            sw = {expected_q[i][7:0], expected_q[i][15:8]};
            a  = (a + int'(sw)) % 65535;
            b  = (b + a) % 65535;
        end
        expected_q.push_back({a[7:0], a[15:8]});
        expected_q.push_back({b[7:0], b[15:8]});
        for (int i = 0; i < PADDING_WORDS; i++) begin
            expected_q.push_back(16'h0000);
        end
    endtask

    task automatic run_readout(input logic [HEADER_W-1:0] h, input bit thumb,
                               input bit backpressure);
        int   cycles;
        logic trig;
        @(negedge clk);
        cmd_readout = 1'b1;
        cmd_header  = h;
        cmd_thumb   = thumb;
        @(negedge clk);
        cmd_readout = 1'b0;
        received_q.delete();
        cycles = 0;
        while (!readout_done) begin
            if (cycles >= READOUT_TIMEOUT) begin
                $display("Timeout at %0t: readout_done never rose", $time);
                stop_on_error();
            end
            trig = backpressure ? (next_rand() % 16'd3 != 16'd0) : 1'b1;
            readout_trigger = trig;
            // Transfer happens at the coming rising edge
            if (readout_ready && trig) begin
                received_q.push_back(readout_data);
            end
            @(negedge clk);
            cycles++;
        end
        readout_trigger = 1'b0;
    endtask

    task automatic compare_stream();
        check_count(COUNT_W'(received_q.size()), COUNT_W'(expected_q.size()),
                    "readout word count");
        foreach (expected_q[i]) begin
            check_word(received_q[i], expected_q[i], $sformatf("readout word %0d", i));
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        arst_n          = 1'b0;
        cmd_capture     = 1'b0;
        cmd_skip_count  = 1'b0;
        cmd_readout     = 1'b0;
        cmd_header      = '0;
        cmd_thumb       = 1'b0;
        img_d           = 12'h000;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        lcg_state       = 32'd30;
        capture_pulses  = 0;
        repeat (3) begin
            @(negedge clk);
        end
        arst_n = 1'b1;
        if (readout_ready || readout_done || capture_done) begin
            $display("CHECK FAILED at %0t: control outputs not idle after reset", $time);
            stop_on_error();
        end

        // First complete frame without skip
        start_capture(1'b0);
        drive_frame(1'b1);
        wait_capture(1);

        // Full readout without stalls
        hdr_full = random_header();
        run_readout(hdr_full, 1'b0, 1'b0);
        build_expected(hdr_full, 1'b0);
        compare_stream();

        // Thumbnail readout
        hdr = random_header();
        run_readout(hdr, 1'b1, 1'b0);
        build_expected(hdr, 1'b1);
        compare_stream();

        // Same full readout under random back-pressure
        run_readout(hdr_full, 1'b0, 1'b1);
        build_expected(hdr_full, 1'b0);
        compare_stream();

        // Skip one frame so the second one is stored
        start_capture(1'b1);
        drive_frame(1'b0);
        drive_frame(1'b1);
        wait_capture(2);
        hdr = random_header();
        run_readout(hdr, 1'b0, 1'b1);
        build_expected(hdr, 1'b0);
        compare_stream();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb/img_ctrl_asserts.sv ====
`timescale 1ns/1ps

module img_ctrl_asserts (
    input logic           clk,
    input logic           arst_n,
    input logic           ready,
    input logic           trigger,
    input img_pkg::word_t data,
    input logic           done,
    input logic           pulse
);

    // A stalled word must stay presented unchanged
    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (ready && !trigger) |=> (ready && $stable(data)))
        else $error("readout word changed or withdrawn while stalled");

    a_done_idle: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> !ready)
        else $error("readout_ready high while readout_done is set");

    a_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        pulse |=> !pulse)
        else $error("pulse longer than one cycle");

endmodule

bind readout_ctrl img_ctrl_asserts u_readout_asserts (
    .clk     (clk),
    .arst_n  (arst_n),
    .ready   (readout_ready),
    .trigger (readout_trigger),
    .data    (readout_data),
    .done    (readout_done),
    .pulse   (sum_clear)
);

bind pixel_capture img_ctrl_asserts u_capture_asserts (
    .clk     (clk),
    .arst_n  (arst_n),
    .ready   (1'b0),
    .trigger (1'b0),
    .data    (16'h0000),
    .done    (1'b0),
    .pulse   (capture_done)
);

// ==== design/img_ctrl_top.sv ====
`timescale 1ns/1ps

module img_ctrl_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         cmd_capture,
    input  logic                         cmd_skip_count,
    input  logic                         cmd_readout,
    input  logic [img_pkg::HEADER_W-1:0] cmd_header,
    input  logic                         cmd_thumb,
    input  logic [11:0]                  img_d,
    input  logic                         img_fv,
    input  logic                         img_lv,
    input  logic                         readout_trigger,
    output img_pkg::word_t               readout_data,
    output logic                         readout_ready,
    output logic                         readout_done,
    output logic                         capture_done,
    output logic [img_pkg::COUNT_W-1:0]  capture_pixel_count,
    output logic [img_pkg::STAT_W-1:0]   capture_highlight_count,
    output logic [img_pkg::STAT_W-1:0]   capture_shadow_count
);
    import img_pkg::*;

    // Frame memory ports
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    pixel_word_u       wr_data;
    logic [ADDR_W-1:0] rd_addr;
    word_t             rd_data;

    // Checksum ports
    logic              sum_clear;
    logic              sum_en;
    word_t             sum_word;
    logic [31:0]       sum;

    pixel_capture u_capture (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .cmd_capture             (cmd_capture),
        .cmd_skip_count          (cmd_skip_count),
        .img_d                   (img_d),
        .img_fv                  (img_fv),
        .img_lv                  (img_lv),
        .wr_en                   (wr_en),
        .wr_addr                 (wr_addr),
        .wr_data                 (wr_data),
        .capture_done            (capture_done),
        .capture_pixel_count     (capture_pixel_count),
        .capture_highlight_count (capture_highlight_count),
        .capture_shadow_count    (capture_shadow_count)
    );

    frame_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fletcher_checksum u_checksum (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum_clear (sum_clear),
        .sum_en    (sum_en),
        .sum_word  (sum_word),
        .sum       (sum)
    );

    readout_ctrl u_readout (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .readout_trigger (readout_trigger),
        .rd_data         (rd_data),
        .sum             (sum),
        .rd_addr         (rd_addr),
        .sum_clear       (sum_clear),
        .sum_en          (sum_en),
        .sum_word        (sum_word),
        .readout_data    (readout_data),
        .readout_ready   (readout_ready),
        .readout_done    (readout_done)
    );

endmodule

// ==== design/readout_ctrl.sv ====
`timescale 1ns/1ps

module readout_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         cmd_readout,
    input  logic [img_pkg::HEADER_W-1:0] cmd_header,
    input  logic                         cmd_thumb,
    input  logic                         readout_trigger,
    input  img_pkg::word_t               rd_data,
    input  logic [31:0]                  sum,
    output logic [img_pkg::ADDR_W-1:0]   rd_addr,
    output logic                         sum_clear,
    output logic                         sum_en,
    output img_pkg::word_t               sum_word,
    output img_pkg::word_t               readout_data,
    output logic                         readout_ready,
    output logic                         readout_done
);
    import img_pkg::*;

    logic [STATE_W-1:0]     state;
    logic [SHIFT_W-1:0]     shift_data;
    logic [SHIFT_CNT_W-1:0] shift_left;
    logic                   thumb_q;
    logic [COUNT_W-1:0]     ptr;
    logic [COUNT_W-1:0]     ptr_prev;
    logic                   data_valid;
    logic [X_W-1:0]         px_x;
    logic [Y_W-1:0]         px_y;
    logic                   load;
    logic                   xfer;
    logic                   keep;
    logic                   take;
    logic                   fetch;
    logic                   shift_step;
    logic                   present;

    // Output register may take a new word when empty or being drained
    assign load = !readout_ready || readout_trigger;
    assign xfer = readout_ready && readout_trigger;

    // ====================
    // Pixel fetch
    // ====================
    // Thumbnail keeps the upper-left 2x2 of each 8x8 block
    assign keep    = !thumb_q || ((px_x[2:0] < 3'd2) && (px_y[2:0] < 3'd2));
    assign take    = data_valid && (!keep || load);
    assign present = (state == RD_PIXELS) && data_valid && keep && load;
    assign fetch   = (state == RD_PIXELS) && (ptr <= COUNT_W'(IMG_PIXELS))
                     && (!data_valid || take);

    // A stalled word is re-read from its own address so rd_data holds
    assign ptr_prev = ptr - 1'b1;
    assign rd_addr  = fetch ? ptr[ADDR_W-1:0] : ptr_prev[ADDR_W-1:0];

    assign shift_step = ((state == RD_HEADER) || (state == RD_TAIL)) && load
                        && (shift_left != '0);

    // ====================
    // Readout sequencer
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= RD_IDLE;
            shift_left    <= '0;
            thumb_q       <= 1'b0;
            ptr           <= '0;
            data_valid    <= 1'b0;
            px_x          <= '0;
            px_y          <= '0;
            readout_ready <= 1'b0;
            readout_done  <= 1'b0;
            sum_clear     <= 1'b0;
            sum_en        <= 1'b0;
        end else begin
            sum_clear <= 1'b0;
            // Only header and pixel words enter the checksum
            sum_en    <= xfer && ((state == RD_HEADER) || (state == RD_PIXELS));

            if (fetch) begin
                ptr        <= ptr + 1'b1;
                data_valid <= ptr < COUNT_W'(IMG_PIXELS);
            end
            if (take) begin
                if (px_x == X_W'(IMG_WIDTH - 1)) begin
                    px_x <= '0;
                    px_y <= px_y + 1'b1;
                end else begin
                    px_x <= px_x + 1'b1;
                end
            end

            case (state)
                RD_HEADER, RD_TAIL: begin
                    if (shift_step) begin
                        readout_ready <= 1'b1;
                        shift_left    <= shift_left - 1'b1;
                    end else if (load) begin
                        readout_ready <= 1'b0;
                        if (state == RD_TAIL) begin
                            readout_done <= 1'b1;
                            state        <= RD_IDLE;
                        end else begin
                            state <= RD_PIXELS;
                        end
                    end
                end
                RD_PIXELS: begin
                    if (load) begin
                        readout_ready <= data_valid && keep;
                    end
                    // Last pixel has been fetched and the output register drained
                    if (load && (ptr > COUNT_W'(IMG_PIXELS))) begin
                        state <= RD_SUM_WAIT;
                    end
                end
                RD_SUM_WAIT: state <= RD_SUM_LOAD;
                RD_SUM_LOAD: begin
                    shift_left <= SHIFT_CNT_W'(TAIL_WORDS);
                    state      <= RD_TAIL;
                end
                default: begin
                end
            endcase

            if (cmd_readout) begin
                state         <= RD_HEADER;
                shift_left    <= SHIFT_CNT_W'(HEADER_WORDS);
                thumb_q       <= cmd_thumb;
                ptr           <= '0;
                data_valid    <= 1'b0;
                px_x          <= '0;
                px_y          <= '0;
                readout_ready <= 1'b0;
                readout_done  <= 1'b0;
                sum_clear     <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Host folds words in little-endian byte order
        sum_word <= {readout_data[7:0], readout_data[15:8]};
        if (cmd_readout) begin
            shift_data[SHIFT_W-1 -: HEADER_W] <= cmd_header;
        end else if (state == RD_SUM_LOAD) begin
            shift_data <= '0;
            shift_data[SHIFT_W-1 -: CHECKSUM_WORDS*16] <=
                {sum[7:0], sum[15:8], sum[23:16], sum[31:24]};
        end else if (shift_step) begin
            readout_data <= shift_data[SHIFT_W-1 -: 16];
            shift_data   <= shift_data << 16;
        end
        if (present) begin
            readout_data <= rd_data;
        end
    end

endmodule

// ==== design/fletcher_checksum.sv ====
`timescale 1ns/1ps

module fletcher_checksum (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           sum_clear,
    input  logic           sum_en,
    input  img_pkg::word_t sum_word,
    output logic [31:0]    sum
);

    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [15:0] next_a;

    // Both operands stay below 65536, so one subtraction completes the modulo
    function automatic logic [15:0] add_mod(input logic [15:0] x, input logic [15:0] y);
        logic [16:0] s;
        s = x + y;
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    assign next_a = add_mod(sum_a, sum_word);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_a <= 16'd0;
            sum_b <= 16'd0;
        end else if (sum_clear) begin
            sum_a <= 16'd0;
            sum_b <= 16'd0;
        end else if (sum_en) begin
            sum_a <= next_a;
            sum_b <= add_mod(sum_b, next_a);
        end
    end

    assign sum = {sum_b, sum_a};

endmodule

// ==== design/pixel_capture.sv ====
`timescale 1ns/1ps

module pixel_capture (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cmd_capture,
    input  logic                        cmd_skip_count,
    input  logic [11:0]                 img_d,
    input  logic                        img_fv,
    input  logic                        img_lv,
    output logic                        wr_en,
    output logic [img_pkg::ADDR_W-1:0]  wr_addr,
    output img_pkg::pixel_word_u        wr_data,
    output logic                        capture_done,
    output logic [img_pkg::COUNT_W-1:0] capture_pixel_count,
    output logic [img_pkg::STAT_W-1:0]  capture_highlight_count,
    output logic [img_pkg::STAT_W-1:0]  capture_shadow_count
);
    import img_pkg::*;

    logic [11:0]        d_q;
    logic [11:0]        d_s2;
    logic               fv_q;
    logic               fv_s2;
    logic               lv_q;
    logic               lv_s2;
    logic               frame_start;
    logic               frame_end;
    logic [1:0]         col;
    logic [1:0]         line;
    logic               grid_s2;
    logic [STATE_W-1:0] state;
    logic               skip_left;
    logic               store_q;
    logic               stat_en;
    logic [6:0]         stat_bits;
    logic               done_d1;

    // ====================
    // Pin sampling
    // ====================
    // Second stage lags the edge detectors so the first pixel after a short blanking is kept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fv_q    <= 1'b0;
            fv_s2   <= 1'b0;
            lv_q    <= 1'b0;
            lv_s2   <= 1'b0;
            col     <= 2'd0;
            line    <= 2'd0;
            grid_s2 <= 1'b0;
        end else begin
            fv_q  <= img_fv;
            fv_s2 <= fv_q;
            lv_q  <= img_lv;
            lv_s2 <= lv_q;
            col   <= lv_q ? col + 2'd1 : 2'd0;
            // Line index counts completed lines
            if (!fv_q) begin
                line <= 2'd0;
            end else if (lv_s2 && !lv_q) begin
                line <= line + 2'd1;
            end
            grid_s2 <= lv_q && (col == 2'd0) && (line == 2'd0);
        end
    end

    always_ff @(posedge clk) begin
        d_q  <= img_d;
        d_s2 <= d_q;
    end

    assign frame_start = fv_q && !fv_s2;
    assign frame_end   = !fv_q && fv_s2;

    // ====================
    // Capture sequencer
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state                   <= CAP_IDLE;
            skip_left               <= 1'b0;
            store_q                 <= 1'b0;
            stat_en                 <= 1'b0;
            done_d1                 <= 1'b0;
            capture_done            <= 1'b0;
            capture_pixel_count     <= '0;
            capture_highlight_count <= '0;
            capture_shadow_count    <= '0;
        end else begin
            store_q      <= 1'b0;
            stat_en      <= 1'b0;
            done_d1      <= 1'b0;
            capture_done <= done_d1;

            if (store_q) begin
                capture_pixel_count <= capture_pixel_count + 1'b1;
            end
            // Top 7 bits decide highlight or shadow
            if (stat_en) begin
                if (&stat_bits) begin
                    capture_highlight_count <= capture_highlight_count + 1'b1;
                end else if (~|stat_bits) begin
                    capture_shadow_count <= capture_shadow_count + 1'b1;
                end
            end

            case (state)
                CAP_CLEAR: begin
                    capture_pixel_count     <= '0;
                    capture_highlight_count <= '0;
                    capture_shadow_count    <= '0;
                    state                   <= CAP_WAIT;
                end
                CAP_WAIT: begin
                    if (frame_start) begin
                        state <= CAP_SKIP;
                    end
                end
                CAP_SKIP: begin
                    skip_left <= 1'b0;
                    state     <= skip_left ? CAP_WAIT : CAP_STORE;
                end
                CAP_STORE: begin
                    store_q <= lv_s2;
                    stat_en <= grid_s2;
                    if (frame_end) begin
                        done_d1 <= 1'b1;
                        state   <= CAP_IDLE;
                    end
                end
                default: begin
                end
            endcase

            if (cmd_capture) begin
                skip_left <= cmd_skip_count;
                state     <= CAP_CLEAR;
            end
        end
    end

    always_ff @(posedge clk) begin
        stat_bits            <= d_s2[11:5];
        wr_data.px.lo_byte   <= d_s2[7:0];
        wr_data.px.zero      <= 4'h0;
        wr_data.px.hi_nibble <= d_s2[11:8];
    end

    // Overflow pixels are still counted but never written
    assign wr_addr = capture_pixel_count[ADDR_W-1:0];
    assign wr_en   = store_q && (capture_pixel_count < COUNT_W'(IMG_PIXELS));

endmodule

// ==== design/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [img_pkg::ADDR_W-1:0] wr_addr,
    input  img_pkg::pixel_word_u       wr_data,
    input  logic [img_pkg::ADDR_W-1:0] rd_addr,
    output img_pkg::word_t             rd_data
);
    import img_pkg::*;

    // One word per pixel of the frame
    word_t mem [IMG_PIXELS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data.raw;
        end
        // Registered read, data follows the address by one cycle
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== design/img_pkg.sv ====
package img_pkg;

    // ====================
    // Image geometry
    // ====================
    localparam int IMG_WIDTH  = 16;
    localparam int IMG_HEIGHT = 16;
    localparam int IMG_PIXELS = IMG_WIDTH * IMG_HEIGHT;
    localparam int ADDR_W     = $clog2(IMG_PIXELS);
    localparam int X_W        = $clog2(IMG_WIDTH);
    localparam int Y_W        = $clog2(IMG_HEIGHT);
    // Pixel count must be able to hold a full frame
    localparam int COUNT_W    = $clog2(IMG_PIXELS + 1);
    localparam int STAT_W     = 18;

    // ====================
    // Stream framing
    // ====================
    localparam int HEADER_WORDS   = 4;
    localparam int CHECKSUM_WORDS = 2;
    localparam int PADDING_WORDS  = 2;
    localparam int TAIL_WORDS     = CHECKSUM_WORDS + PADDING_WORDS;
    localparam int HEADER_W       = HEADER_WORDS * 16;
    // Shift register fits the longer of header and tail
    localparam int SHIFT_WORDS = (HEADER_WORDS > TAIL_WORDS) ? HEADER_WORDS : TAIL_WORDS;
    localparam int SHIFT_W     = SHIFT_WORDS * 16;
    localparam int SHIFT_CNT_W = $clog2(SHIFT_WORDS + 1);

    // FSM encodings
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] CAP_IDLE    = 3'd0;
    localparam logic [STATE_W-1:0] CAP_CLEAR   = 3'd1;
    localparam logic [STATE_W-1:0] CAP_WAIT    = 3'd2;
    localparam logic [STATE_W-1:0] CAP_SKIP    = 3'd3;
    localparam logic [STATE_W-1:0] CAP_STORE   = 3'd4;
    localparam logic [STATE_W-1:0] RD_IDLE     = 3'd0;
    localparam logic [STATE_W-1:0] RD_HEADER   = 3'd1;
    localparam logic [STATE_W-1:0] RD_PIXELS   = 3'd2;
    localparam logic [STATE_W-1:0] RD_SUM_WAIT = 3'd3;
    localparam logic [STATE_W-1:0] RD_SUM_LOAD = 3'd4;
    localparam logic [STATE_W-1:0] RD_TAIL     = 3'd5;

    typedef logic [15:0] word_t;

    // Stored pixel, low byte first for the little-endian host
    typedef union packed {
        word_t raw;
        struct packed {
            logic [7:0] lo_byte;
            logic [3:0] zero;
            logic [3:0] hi_nibble;
        } px;
    } pixel_word_u;

endpackage
